// File: hw/line_conv_engine.sv
`timescale 1ns/1ps

module line_conv_engine import line_conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  conf_t       i_conf,
    input  tap_weight_t i_weight,
    input  logic        i_weight_val,
    output logic        o_weight_req,
    input  pixel_t      i_data,
    input  logic        i_data_val,
    output logic        o_data_req,
    output logic        o_data_end,
    output psum_vec_t   o_psum,
    output logic        o_psum_val,
    output logic        o_psum_end
);

    ////////////////////////////////////////
    // Internal wiring

    tap_weight_t weights [NUM_TAPS];
    logic        weights_loaded;

    window_t     window;
    logic        window_val;
    logic        window_line_last;

    psum_vec_t   tap_psum [NUM_TAPS];
    logic        tap_val [NUM_TAPS];
    logic        tap_line_last [NUM_TAPS];

    ////////////////////////////////////////
    // Weight load and pixel window

    weight_store weight_store_i (
        .clk          (clk),
        .rst          (rst),
        .i_enable     (i_conf.enable),
        .i_weight     (i_weight),
        .i_weight_val (i_weight_val),
        .o_weight_req (o_weight_req),
        .o_weights    (weights),
        .o_loaded     (weights_loaded)
    );

    window_buffer window_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .i_enable     (i_conf.enable),
        .i_loaded     (weights_loaded),
        .i_line_width (i_conf.line_width),
        .i_data       (i_data),
        .i_data_val   (i_data_val),
        .o_data_req   (o_data_req),
        .o_data_end   (o_data_end),
        .o_window     (window),
        .o_window_val (window_val),
        .o_line_last  (window_line_last)
    );

    ////////////////////////////////////////
    // One PE per tap, slot n meets weight word n

    for (genvar n = 0; n < NUM_TAPS; n++) begin : g_tap
        tap_pe tap_pe_i (
            .clk         (clk),
            .rst         (rst),
            .i_pixel     (window[n]),
            .i_weight    (weights[n]),
            .i_val       (window_val),
            .i_line_last (window_line_last),
            .o_psum      (tap_psum[n]),
            .o_val       (tap_val[n]),
            .o_line_last (tap_line_last[n])
        );
    end

    // All PEs run in lockstep so PE 0 carries the flags
    psum_reducer psum_reducer_i (
        .clk           (clk),
        .rst           (rst),
        .i_frame_lines (i_conf.frame_lines),
        .i_tap_psum    (tap_psum),
        .i_val         (tap_val[0]),
        .i_line_last   (tap_line_last[0]),
        .o_psum        (o_psum),
        .o_psum_val    (o_psum_val),
        .o_psum_end    (o_psum_end)
    );

endmodule

// File: hw/line_conv_pkg.sv
package line_conv_pkg;

    ////////////////////////////////////////
    // Engine sizes

    // Channels per pixel
    localparam int NUM_CHANNEL = 3;
    // Kernels computed side by side
    localparam int NUM_KERNEL  = 4;
    // Kernel width, one tap PE per tap
    localparam int NUM_TAPS    = 3;

    localparam int ACT_W  = 8;
    localparam int WGT_W  = 8;
    localparam int PSUM_W = 20;
    localparam int POS_W  = 8;

    ////////////////////////////////////////
    // Element types

    // Unsigned activation
    typedef logic [ACT_W-1:0]  act_t;
    // Signed weight, sign applied at the multiplier
    typedef logic [WGT_W-1:0]  wgt_t;
    typedef logic [PSUM_W-1:0] psum_t;
    typedef logic [POS_W-1:0]  pos_t;

    ////////////////////////////////////////
    // Bus types

    // Channel 0 in the low bits
    typedef act_t [NUM_CHANNEL-1:0] pixel_t;

    // Indexed [kernel][channel], kernel 0 in the low bits
    typedef wgt_t [NUM_KERNEL-1:0][NUM_CHANNEL-1:0] tap_weight_t;

    typedef psum_t [NUM_KERNEL-1:0] psum_vec_t;

    // Slot 0 holds the oldest pixel
    typedef pixel_t [NUM_TAPS-1:0] window_t;

    // Engine configuration, held stable after reset
    typedef struct packed {
        logic enable;
        pos_t line_width;
        pos_t frame_lines;
    } conf_t;

endpackage

// File: hw/psum_reducer.sv
`timescale 1ns/1ps

module psum_reducer import line_conv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  pos_t      i_frame_lines,
    input  psum_vec_t i_tap_psum [NUM_TAPS],
    input  logic      i_val,
    input  logic      i_line_last,
    output psum_vec_t o_psum,
    output logic      o_psum_val,
    output logic      o_psum_end
);

    psum_vec_t tap_sum;
    psum_vec_t psum_q;
    logic      psum_val_q;
    logic      psum_end_q;
    pos_t      line_cnt;
    logic      line_done;
    logic      frame_done;

    ////////////////////////////////////////
    // Cross-tap sum per kernel

    always_comb begin : tap_add
        logic signed [PSUM_W-1:0] acc;
        for (int k = 0; k < NUM_KERNEL; k++) begin
            acc = '0;
            for (int t = 0; t < NUM_TAPS; t++) begin
                acc = acc + $signed(i_tap_psum[t][k]);
            end
            tap_sum[k] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (i_val) begin
            psum_q <= tap_sum;
        end
    end

    ////////////////////////////////////////
    // Line count and frame end

    assign line_done  = i_val && i_line_last;
    assign frame_done = (line_cnt == i_frame_lines - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            psum_val_q <= 1'b0;
            psum_end_q <= 1'b0;
            line_cnt   <= '0;
        end else begin
            psum_val_q <= i_val;
            // Marks the last output of the frame's final line
            psum_end_q <= line_done && frame_done;
            if (line_done) begin
                line_cnt <= frame_done ? '0 : line_cnt + 1'b1;
            end
        end
    end

    assign o_psum     = psum_q;
    assign o_psum_val = psum_val_q;
    assign o_psum_end = psum_end_q;

endmodule

// File: hw/tap_pe.sv
`timescale 1ns/1ps

module tap_pe import line_conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pixel_t      i_pixel,
    input  tap_weight_t i_weight,
    input  logic        i_val,
    input  logic        i_line_last,
    output psum_vec_t   o_psum,
    output logic        o_val,
    output logic        o_line_last
);

    psum_vec_t dot;
    psum_vec_t psum_q;
    logic      val_q;
    logic      line_last_q;

    ////////////////////////////////////////
    // Channel dot product per kernel

    always_comb begin : dot_calc
        logic signed [PSUM_W-1:0] prod;
        logic signed [PSUM_W-1:0] acc;
        for (int k = 0; k < NUM_KERNEL; k++) begin
            acc = '0;
            for (int c = 0; c < NUM_CHANNEL; c++) begin
                // Zero-extend activation so the product stays signed
                prod = $signed({1'b0, i_pixel[c]}) * $signed(i_weight[k][c]);
                acc  = acc + prod;
            end
            dot[k] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (i_val) begin
            psum_q <= dot;
        end
    end

    // Flags follow the window every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            val_q       <= 1'b0;
            line_last_q <= 1'b0;
        end else begin
            val_q       <= i_val;
            line_last_q <= i_line_last;
        end
    end

    assign o_psum      = psum_q;
    assign o_val       = val_q;
    assign o_line_last = line_last_q;

endmodule

// File: hw/weight_store.sv
`timescale 1ns/1ps

module weight_store import line_conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_enable,
    input  tap_weight_t i_weight,
    input  logic        i_weight_val,
    output logic        o_weight_req,
    output tap_weight_t o_weights [NUM_TAPS],
    output logic        o_loaded
);

    localparam int IDX_W = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;

    logic             weight_req;
    logic             loaded;
    logic [IDX_W-1:0] tap_idx;
    logic             weight_accept;
    logic             last_tap;
    tap_weight_t      weight_mem [NUM_TAPS];

    assign weight_accept = weight_req && i_weight_val;
    assign last_tap      = (tap_idx == IDX_W'(NUM_TAPS - 1));

    ////////////////////////////////////////
    // Request and tap index

    always_ff @(posedge clk) begin
        if (rst) begin
            weight_req <= 1'b0;
            loaded     <= 1'b0;
            tap_idx    <= '0;
        end else if (weight_accept) begin
            if (last_tap) begin
                // Last word in, stop asking for good
                weight_req <= 1'b0;
                loaded     <= 1'b1;
                tap_idx    <= '0;
            end else begin
                tap_idx <= tap_idx + 1'b1;
            end
        end else if (i_enable && !loaded) begin
            weight_req <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Weight words, one slot per tap

    always_ff @(posedge clk) begin
        if (weight_accept) begin
            weight_mem[tap_idx] <= i_weight;
        end
    end

    assign o_weight_req = weight_req;
    assign o_weights    = weight_mem;
    assign o_loaded     = loaded;

endmodule

// File: hw/window_buffer.sv
`timescale 1ns/1ps

module window_buffer import line_conv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_enable,
    input  logic    i_loaded,
    input  pos_t    i_line_width,
    input  pixel_t  i_data,
    input  logic    i_data_val,
    output logic    o_data_req,
    output logic    o_data_end,
    output window_t o_window,
    output logic    o_window_val,
    output logic    o_line_last
);

    logic    data_req;
    logic    data_accept;
    pos_t    pos;
    pos_t    last_pos;
    logic    at_line_end;
    logic    window_full;
    window_t window;
    logic    window_val;
    logic    line_last;

    assign data_accept = data_req && i_data_val;
    assign last_pos    = i_line_width - 1'b1;
    assign at_line_end = (pos == last_pos);

    // Earlier positions still hold pixels of the previous line
    assign window_full = (pos >= pos_t'(NUM_TAPS - 1));

    ////////////////////////////////////////
    // Data request level

    always_ff @(posedge clk) begin
        if (rst) begin
            data_req <= 1'b0;
        end else begin
            data_req <= i_enable && i_loaded;
        end
    end

    ////////////////////////////////////////
    // Position in line and window flags

    always_ff @(posedge clk) begin
        if (rst) begin
            pos        <= '0;
            window_val <= 1'b0;
            line_last  <= 1'b0;
        end else begin
            window_val <= data_accept && window_full;
            line_last  <= data_accept && at_line_end;
            if (data_accept) begin
                pos <= at_line_end ? '0 : pos + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Sliding window

    // Newest pixel enters the top slot, oldest drops out of slot 0
    always_ff @(posedge clk) begin
        if (data_accept) begin
            window <= {i_data, window[NUM_TAPS-1:1]};
        end
    end

    assign o_data_req   = data_req;
    assign o_data_end   = line_last;
    assign o_window     = window;
    assign o_window_val = window_val;
    assign o_line_last  = line_last;

endmodule

// File: list.f
+incdir+verif
hw/line_conv_pkg.sv
hw/weight_store.sv
hw/window_buffer.sv
hw/tap_pe.sv
hw/psum_reducer.sv
hw/line_conv_engine.sv
verif/clk_gen.sv
verif/tb_line_conv_engine.sv

// File: verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    localparam int RESET_CYCLES = 16;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Released after the last reset edge so the DUT sees all 16
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verif/line_conv_model.svh
`ifndef LINE_CONV_MODEL_SVH
`define LINE_CONV_MODEL_SVH

// Accepted weight words, one per tap
tap_weight_t model_weights [NUM_TAPS];
// Pixels of the line in progress
pixel_t      line_pixels [$];
int          model_lines = 0;

// Expected results in output order
psum_vec_t   exp_psum [$];
int          exp_cycle [$];
bit          exp_frame_end [$];
// Acceptance cycle of each line's last pixel
int          exp_data_end [$];
int          exp_line_end [$];

// Dot product of the window ending at position x with all taps
function automatic psum_vec_t window_sum(int x);
    psum_vec_t res;
    int        acc;
    for (int k = 0; k < NUM_KERNEL; k++) begin
        acc = 0;
        for (int p = 0; p < NUM_TAPS; p++) begin
            for (int c = 0; c < NUM_CHANNEL; c++) begin
                acc += int'(line_pixels[x - NUM_TAPS + 1 + p][c])
                     * int'($signed(model_weights[p][k][c]));
            end
        end
        res[k] = psum_t'(acc);
    end
    return res;
endfunction

// Pixel accepted at the edge that closes cycle acc_cycle
function automatic void model_pixel(pixel_t px, int acc_cycle);
    int x;
    line_pixels.push_back(px);
    x = line_pixels.size() - 1;
    // Windows reaching into the previous line give no output
    if (x >= NUM_TAPS - 1) begin
        exp_psum.push_back(window_sum(x));
        exp_cycle.push_back(acc_cycle);
        exp_frame_end.push_back(x == LINE_WIDTH - 1 && model_lines == FRAME_LINES - 1);
    end
    if (x == LINE_WIDTH - 1) begin
        exp_data_end.push_back(acc_cycle);
        exp_line_end.push_back(acc_cycle);
        model_lines = (model_lines == FRAME_LINES - 1) ? 0 : model_lines + 1;
        line_pixels.delete();
    end
endfunction

`endif

// File: verif/tb_line_conv_engine.sv
`timescale 1ns/1ps

module tb_line_conv_engine import line_conv_pkg::*; ();

    localparam int LINE_WIDTH   = 10;
    localparam int FRAME_LINES  = 3;
    localparam int NUM_FRAMES   = 4;
    localparam int TOTAL_PIXELS = LINE_WIDTH * FRAME_LINES * NUM_FRAMES;
    localparam int LINE_OUTPUTS = LINE_WIDTH - NUM_TAPS + 1;
    localparam int TIMEOUT      = 2000;

    logic        clk;
    logic        rst;
    conf_t       i_conf;
    tap_weight_t i_weight;
    logic        i_weight_val;
    logic        o_weight_req;
    pixel_t      i_data;
    logic        i_data_val;
    logic        o_data_req;
    logic        o_data_end;
    psum_vec_t   o_psum;
    logic        o_psum_val;
    logic        o_psum_end;

    int cycle = 0;
    int wait_cnt;
    int value_errors = 0;
    int count_errors = 0;
    int cycle_errors = 0;
    int other_errors = 0;
    int timeouts = 0;
    int weight_words = 0;
    int pixels_sent = 0;
    int psum_outputs = 0;
    int line_outputs = 0;
    int data_ends = 0;
    int frame_ends = 0;

    `include "line_conv_model.svh"

    clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    line_conv_engine line_conv_engine_i (
        .clk          (clk),
        .rst          (rst),
        .i_conf       (i_conf),
        .i_weight     (i_weight),
        .i_weight_val (i_weight_val),
        .o_weight_req (o_weight_req),
        .i_data       (i_data),
        .i_data_val   (i_data_val),
        .o_data_req   (o_data_req),
        .o_data_end   (o_data_end),
        .o_psum       (o_psum),
        .o_psum_val   (o_psum_val),
        .o_psum_end   (o_psum_end)
    );

    // Posedge number, read at the falling edge
    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////
    // Compare tasks

    task automatic check_psum(string name, psum_vec_t exp, psum_vec_t act);
        if (exp !== act) begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            count_errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_cycle(string name, int exp, int act);
        if (exp != act) begin
            cycle_errors++;
            $display("Fail %s: expected cycle %0d, actual cycle %0d", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Output monitor and wait step

    task automatic check_outputs();
        if (o_psum_val) begin
            line_outputs++;
            if (exp_psum.size() == 0) begin
                other_errors++;
                $display("Output valid at cycle %0d while no result was due", cycle);
            end else begin
                psum_outputs++;
                check_psum("psum_value", exp_psum.pop_front(), o_psum);
                check_cycle("psum_latency", exp_cycle.pop_front() + 3, cycle);
                check_count("psum_end_flag", int'(exp_frame_end.pop_front()), int'(o_psum_end));
            end
        end else if (o_psum_end) begin
            other_errors++;
            $display("Frame end raised without a valid output at cycle %0d", cycle);
        end
        // Line closes with the output of its last window
        if (exp_line_end.size() > 0 && cycle == exp_line_end[0] + 3) begin
            exp_line_end.delete(0);
            check_count("outputs_per_line", LINE_OUTPUTS, line_outputs);
            line_outputs = 0;
        end
        if (o_psum_end) frame_ends++;
        if (o_data_end) begin
            data_ends++;
            if (exp_data_end.size() == 0) begin
                other_errors++;
                $display("End of line pulse at cycle %0d with no line completed", cycle);
            end else begin
                check_cycle("data_end_latency", exp_data_end.pop_front() + 1, cycle);
            end
        end
    endtask

    // One falling edge of a wait loop, gives up after TIMEOUT cycles
    task automatic next_cycle(string what);
        @(negedge clk);
        wait_cnt++;
        check_outputs();
        if (wait_cnt > TIMEOUT) begin
            timeouts++;
            $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus

    initial begin
        i_conf       = '{enable: 1'b1, line_width: pos_t'(LINE_WIDTH),
                         frame_lines: pos_t'(FRAME_LINES)};
        i_weight     = '0;
        i_weight_val = 1'b0;
        i_data       = '0;
        i_data_val   = 1'b0;
        void'($urandom(80));

        wait_cnt = 0;
        while (rst !== 1'b0 && timeouts == 0) next_cycle("reset release");
        check_count("outputs_after_reset", 0,
                    int'({o_weight_req, o_data_req, o_data_end, o_psum_val, o_psum_end}));

        wait_cnt = 0;
        while (!o_weight_req && timeouts == 0) next_cycle("weight request");

        // Weight load, words in tap order
        wait_cnt = 0;
        while (o_weight_req && timeouts == 0) begin
            if (o_data_req) begin
                other_errors++;
                $display("Data request raised before the weights were loaded");
            end
            i_weight_val = ($urandom % 100) < 70;
            i_weight     = {$urandom, $urandom, $urandom};
            if (i_weight_val) begin
                if (weight_words < NUM_TAPS) model_weights[weight_words] = i_weight;
                weight_words++;
            end
            next_cycle("drop of the weight request");
        end
        i_weight_val = 1'b0;
        check_count("weight_words", NUM_TAPS, weight_words);

        // Pixel stream with random gaps
        wait_cnt = 0;
        while (pixels_sent < TOTAL_PIXELS && timeouts == 0) begin
            i_data_val = 1'b0;
            if (o_data_req && ($urandom % 100) < 70) begin
                i_data     = pixel_t'($urandom);
                i_data_val = 1'b1;
                model_pixel(i_data, cycle);
                pixels_sent++;
            end
            next_cycle("acceptance of all pixels");
        end
        i_data_val = 1'b0;

        wait_cnt = 0;
        while ((exp_psum.size() > 0 || exp_data_end.size() > 0) && timeouts == 0) begin
            next_cycle("remaining outputs");
        end
        // Quiet outputs once the stream is done
        wait_cnt = 0;
        repeat (8) next_cycle("idle cycle");

        check_count("total_outputs", TOTAL_PIXELS / LINE_WIDTH * LINE_OUTPUTS, psum_outputs);
        check_count("data_end_pulses", TOTAL_PIXELS / LINE_WIDTH, data_ends);
        check_count("frame_ends", NUM_FRAMES, frame_ends);

        $display("Errors: value %0d, count %0d, cycle %0d, timeout %0d, other %0d",
                 value_errors, count_errors, cycle_errors, timeouts, other_errors);
        if (value_errors + count_errors + cycle_errors + timeouts + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
